/* logic/fetch_mmu_pkg.sv */
// Shared types for the fetch MMU and cache.
// Descriptor layout, request and response words, fault codes.
`default_nettype none

package fetch_mmu_pkg;

        // --------------------
        // Basic words.
        // --------------------
        typedef logic [31:0] word_t;            // Data word or address.

        localparam int LINE_WORDS = 4;          // 16-byte cache line.

        localparam logic [1:0] DESC_SECTION = 2'd2; // Section type code.

        // Fetch status.
        typedef enum logic [1:0] {
                FAULT_NONE        = 2'd0,
                FAULT_TRANSLATION = 2'd1,       // Not a section descriptor.
                FAULT_PERMISSION  = 2'd2
        } fault_e;

        // --------------------
        // First-level descriptor.
        // --------------------
        typedef struct packed {
                logic [11:0] base;              // Physical section base.
                logic [7:0]  rsvd0;
                logic [1:0]  ap;                // Access permission.
                logic [4:0]  rsvd1;
                logic        c;                 // Cacheable.
                logic        b;                 // Bufferable.
                logic        rsvd2;
                logic [1:0]  kind;              // 2 means section.
        } section_desc_t;

        // RAM word, either a descriptor (walk) or instruction data.
        typedef union packed {
                section_desc_t desc;
                word_t         word;
        } ram_word_u;

        // --------------------
        // Request and response.
        // --------------------
        typedef struct packed {
                word_t vaddr;                   // Virtual fetch address.
                logic  user;                    // User-mode fetch.
        } fetch_req_t;

        typedef struct packed {
                word_t  data;                   // Zero on a fault.
                fault_e status;
        } fetch_rsp_t;

        // Cached translation of one section.
        typedef struct packed {
                logic [11:0] tag;               // Virtual section number.
                logic [11:0] base;              // Physical section base.
                logic [1:0]  ap;
                logic        c;
        } tlb_entry_t;

endpackage

`default_nettype wire

/* logic/section_tlb.sv */
// Direct-mapped section TLB.
// Combinational lookup, single-entry write, bulk invalidate.
`default_nettype none

module section_tlb
#(
        parameter int TLB_ENTRIES = 16
)
(
        input  logic                       i_clk,
        input  logic                       i_reset,
        input  logic                       i_inv,        // Clears all valid bits.
        input  fetch_mmu_pkg::word_t       i_lookup_va,
        output logic                       o_hit,
        output fetch_mmu_pkg::tlb_entry_t  o_entry,
        input  logic                       i_wr_en,
        input  fetch_mmu_pkg::tlb_entry_t  i_wr_entry
);
        import fetch_mmu_pkg::*;

        localparam int IDX_W = $clog2(TLB_ENTRIES);

        tlb_entry_t             entries [TLB_ENTRIES];  // Entry store.
        logic [TLB_ENTRIES-1:0] valid_q;
        logic [IDX_W-1:0]       rd_idx;
        logic [IDX_W-1:0]       wr_idx;

        // Low bits of the section number pick the slot.
        assign rd_idx = i_lookup_va[20 +: IDX_W];
        assign wr_idx = i_wr_entry.tag[IDX_W-1:0];

        // Full 12-bit tag compare.
        assign o_entry = entries[rd_idx];
        assign o_hit   = valid_q[rd_idx] && (entries[rd_idx].tag == i_lookup_va[31:20]);

        // --------------------
        // Valid bits.
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                        valid_q <= '0;          // Invalidate wins over a write.
                else if (i_wr_en)
                        valid_q[wr_idx] <= 1'b1;
        end

        // Entry store.
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                        entries[wr_idx] <= i_wr_entry;
        end

endmodule

`default_nettype wire

/* logic/line_cache.sv */
// Direct-mapped instruction cache of 16-byte lines.
// Tag compare, word select and whole-line fill.
`default_nettype none

module line_cache
#(
        parameter int CACHE_LINES = 32
)
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_inv,            // Clears all valid bits.
        input  fetch_mmu_pkg::word_t  i_lookup_pa,
        output logic                  o_hit,
        output fetch_mmu_pkg::word_t  o_word,
        input  logic                  i_fill_en,
        input  fetch_mmu_pkg::word_t [fetch_mmu_pkg::LINE_WORDS-1:0] i_fill_line
);
        import fetch_mmu_pkg::*;

        localparam int IDX_W = $clog2(CACHE_LINES);
        localparam int TAG_W = 28 - IDX_W;              // Above index and offset.

        // --------------------
        // Storage.
        // --------------------
        logic [TAG_W-1:0]       tags  [CACHE_LINES];
        word_t [LINE_WORDS-1:0] lines [CACHE_LINES];
        logic [CACHE_LINES-1:0] valid_q;

        // Address split.
        logic [IDX_W-1:0]       idx;
        logic [TAG_W-1:0]       tag;
        logic [1:0]             sel;

        assign idx = i_lookup_pa[4 +: IDX_W];
        assign tag = i_lookup_pa[31 -: TAG_W];
        assign sel = i_lookup_pa[3:2];                  // Word in line.

        // Combinational read.
        assign o_hit  = valid_q[idx] && (tags[idx] == tag);
        assign o_word = lines[idx][sel];

        // --------------------
        // Valid bits.
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                        valid_q <= '0;
                else if (i_fill_en)
                        valid_q[idx] <= 1'b1;
        end

        // Line and tag written together, at the lookup address.
        always_ff @(posedge i_clk)
        begin
                if (i_fill_en)
                begin
                        tags[idx]  <= tag;
                        lines[idx] <= i_fill_line;
                end
        end

endmodule

`default_nettype wire

/* logic/fetch_walker.sv */
// Fetch control FSM: lookup, section table walk, line fill, uncached read.
// Drives the TLB, the cache and the RAM port, and answers each request.
`default_nettype none

module fetch_walker
(
        input  logic                       i_clk,
        input  logic                       i_reset,
        // Requester.
        input  logic                       i_req,
        input  fetch_mmu_pkg::fetch_req_t  i_req_data,
        output logic                       o_busy,
        output logic                       o_done,
        output fetch_mmu_pkg::fetch_rsp_t  o_rsp,
        // Configuration.
        input  logic                       i_mmu_en,
        input  fetch_mmu_pkg::word_t       i_table_base,
        // RAM.
        output logic                       o_ram_rd_en,
        output fetch_mmu_pkg::word_t       o_ram_addr,
        input  logic                       i_ram_done,
        input  fetch_mmu_pkg::word_t       i_ram_rd_data,
        // TLB.
        output fetch_mmu_pkg::word_t       o_tlb_va,
        input  logic                       i_tlb_hit,
        input  fetch_mmu_pkg::tlb_entry_t  i_tlb_entry,
        output logic                       o_tlb_wr_en,
        output fetch_mmu_pkg::tlb_entry_t  o_tlb_wr_entry,
        // Cache.
        output fetch_mmu_pkg::word_t       o_cache_pa,
        input  logic                       i_cache_hit,
        input  fetch_mmu_pkg::word_t       i_cache_word,
        output logic                       o_fill_en,
        output fetch_mmu_pkg::word_t [fetch_mmu_pkg::LINE_WORDS-1:0] o_fill_line
);
        import fetch_mmu_pkg::*;

        localparam logic [1:0] LAST_WORD = 2'(LINE_WORDS - 1);

        typedef enum logic [2:0] {
                S_IDLE,
                S_LOOKUP,
                S_WALK,
                S_FILL,
                S_UNCACHED
        } state_e;

        // --------------------
        // Registers.
        // --------------------
        state_e                 state_q, state_d;
        fetch_req_t             req_q;                  // Request in flight.
        word_t                  pa_q;                   // Physical address for RAM.
        logic [1:0]             fill_cnt_q;             // Word being filled.
        word_t [LINE_WORDS-2:0] line_buf_q;             // First three fill words.
        logic                   done_q;                 // Late answer pending.
        fetch_rsp_t             rsp_q;
        logic                   ram_ack_q;              // RAM answered last cycle.

        // Decode.
        word_t                  pa;
        logic                   cacheable;
        logic                   ram_ok;
        logic                   walk_fault;
        logic                   lookup_done;
        fetch_rsp_t             lookup_rsp;
        ram_word_u              ram_word;

        // Section base joined with the low 20 virtual bits.
        assign pa        = i_mmu_en ? {i_tlb_entry.base, req_q.vaddr[19:0]} : req_q.vaddr;
        assign cacheable = !i_mmu_en || i_tlb_entry.c;  // Flat map is always cached.

        assign ram_word   = ram_word_u'(i_ram_rd_data);
        assign ram_ok     = o_ram_rd_en && i_ram_done;
        assign walk_fault = ram_word.desc.kind != DESC_SECTION;

        // --------------------
        // Next state.
        // --------------------
        always_comb
        begin
                state_d     = state_q;
                lookup_done = 1'b0;
                lookup_rsp  = '{data: '0, status: FAULT_NONE};
                o_tlb_wr_en = 1'b0;
                o_fill_en   = 1'b0;
                case (state_q)
                S_IDLE:
                        if (i_req)
                                state_d = S_LOOKUP;
                S_LOOKUP:
                begin
                        if (i_mmu_en && !i_tlb_hit)
                                state_d = S_WALK;       // No translation yet.
                        else if (i_mmu_en && req_q.user && !i_tlb_entry.ap[1])
                        begin
                                lookup_done       = 1'b1;
                                lookup_rsp.status = FAULT_PERMISSION;
                                state_d           = S_IDLE;
                        end
                        else if (!cacheable)
                                state_d = S_UNCACHED;
                        else if (i_cache_hit)
                        begin
                                lookup_done     = 1'b1; // One-cycle hit.
                                lookup_rsp.data = i_cache_word;
                                state_d         = S_IDLE;
                        end
                        else
                                state_d = S_FILL;
                end
                S_WALK:
                begin
                        if (ram_ok)
                        begin
                                o_tlb_wr_en = !walk_fault;
                                state_d     = walk_fault ? S_IDLE : S_LOOKUP;
                        end
                end
                S_FILL:
                begin
                        if (ram_ok && fill_cnt_q == LAST_WORD)
                        begin
                                o_fill_en = 1'b1;       // Whole line at once.
                                state_d   = S_LOOKUP;
                        end
                end
                S_UNCACHED:
                        if (ram_ok)
                                state_d = S_IDLE;
                default:
                        state_d = S_IDLE;
                endcase
        end

        // --------------------
        // RAM port.
        // --------------------
        // Read enable drops for one cycle after each answer.
        assign o_ram_rd_en = (state_q inside {S_WALK, S_FILL, S_UNCACHED}) && !ram_ack_q;

        always_comb
        begin
                case (state_q)
                S_WALK:  o_ram_addr = {i_table_base[31:14], req_q.vaddr[31:20], 2'b00};
                S_FILL:  o_ram_addr = {pa_q[31:4], fill_cnt_q, 2'b00};
                default: o_ram_addr = pa_q;
                endcase
        end

        // Lookup side.
        assign o_tlb_va       = req_q.vaddr;
        assign o_cache_pa     = (state_q == S_LOOKUP) ? pa : pa_q;
        assign o_tlb_wr_entry = '{tag:  req_q.vaddr[31:20],
                                  base: ram_word.desc.base,
                                  ap:   ram_word.desc.ap,
                                  c:    ram_word.desc.c};
        assign o_fill_line    = {ram_word.word, line_buf_q};

        // Answer now from lookup, or one cycle after the RAM.
        assign o_done = lookup_done || done_q;
        assign o_rsp  = lookup_done ? lookup_rsp : rsp_q;
        assign o_busy = (state_q != S_IDLE) || done_q;

        // --------------------
        // Control state.
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q    <= S_IDLE;
                        done_q     <= 1'b0;
                        ram_ack_q  <= 1'b0;
                        fill_cnt_q <= '0;
                end
                else
                begin
                        state_q   <= state_d;
                        ram_ack_q <= ram_ok;
                        done_q    <= ram_ok && ((state_q == S_UNCACHED) ||
                                                (state_q == S_WALK && walk_fault));
                        if (state_q == S_LOOKUP)
                                fill_cnt_q <= '0;
                        else if (state_q == S_FILL && ram_ok)
                                fill_cnt_q <= fill_cnt_q + 2'd1;
                end
        end

        // Payload.
        always_ff @(posedge i_clk)
        begin
                if (i_req && state_q == S_IDLE)
                        req_q <= i_req_data;
                if (state_q == S_LOOKUP)
                        pa_q <= pa;
                if (state_q == S_FILL && ram_ok && fill_cnt_q != LAST_WORD)
                        line_buf_q[fill_cnt_q] <= ram_word.word;
                if (ram_ok)                             // Only read when done_q follows.
                        rsp_q <= (state_q == S_UNCACHED) ?
                                 '{data: ram_word.word, status: FAULT_NONE} :
                                 '{data: '0, status: FAULT_TRANSLATION};
        end

endmodule

`default_nettype wire

/* logic/fetch_mmu_top.sv */
// Instruction-fetch MMU and cache, top level.
// Joins the fetch FSM to the section TLB and the line cache.
`default_nettype none

module fetch_mmu_top
#(
        parameter int TLB_ENTRIES = 16,
        parameter int CACHE_LINES = 32
)
(
        input  logic                       i_clk,
        input  logic                       i_reset,
        input  logic                       i_req,
        input  fetch_mmu_pkg::fetch_req_t  i_req_data,
        output logic                       o_busy,
        output logic                       o_done,
        output fetch_mmu_pkg::fetch_rsp_t  o_rsp,
        input  logic                       i_mmu_en,
        input  fetch_mmu_pkg::word_t       i_table_base,  // Bits 13:0 ignored.
        input  logic                       i_inv,         // TLB and cache flush.
        output logic                       o_ram_rd_en,
        output fetch_mmu_pkg::word_t       o_ram_addr,
        input  logic                       i_ram_done,
        input  fetch_mmu_pkg::word_t       i_ram_rd_data
);
        import fetch_mmu_pkg::*;

        // --------------------
        // Walker to TLB.
        // --------------------
        word_t                  tlb_va;
        logic                   tlb_hit;
        tlb_entry_t             tlb_entry;
        logic                   tlb_wr_en;
        tlb_entry_t             tlb_wr_entry;

        // Walker to cache.
        word_t                  cache_pa;
        logic                   cache_hit;
        word_t                  cache_word;
        logic                   fill_en;
        word_t [LINE_WORDS-1:0] fill_line;

        fetch_walker u_walker (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_req          (i_req),
                .i_req_data     (i_req_data),
                .o_busy         (o_busy),
                .o_done         (o_done),
                .o_rsp          (o_rsp),
                .i_mmu_en       (i_mmu_en),
                .i_table_base   (i_table_base),
                .o_ram_rd_en    (o_ram_rd_en),
                .o_ram_addr     (o_ram_addr),
                .i_ram_done     (i_ram_done),
                .i_ram_rd_data  (i_ram_rd_data),
                .o_tlb_va       (tlb_va),
                .i_tlb_hit      (tlb_hit),
                .i_tlb_entry    (tlb_entry),
                .o_tlb_wr_en    (tlb_wr_en),
                .o_tlb_wr_entry (tlb_wr_entry),
                .o_cache_pa     (cache_pa),
                .i_cache_hit    (cache_hit),
                .i_cache_word   (cache_word),
                .o_fill_en      (fill_en),
                .o_fill_line    (fill_line)
        );

        section_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_inv          (i_inv),
                .i_lookup_va    (tlb_va),
                .o_hit          (tlb_hit),
                .o_entry        (tlb_entry),
                .i_wr_en        (tlb_wr_en),
                .i_wr_entry     (tlb_wr_entry)
        );

        line_cache #(.CACHE_LINES(CACHE_LINES)) u_cache (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_inv          (i_inv),
                .i_lookup_pa    (cache_pa),
                .o_hit          (cache_hit),
                .o_word         (cache_word),
                .i_fill_en      (fill_en),
                .i_fill_line    (fill_line)
        );

endmodule

`default_nettype wire

/* verif/fetch_mmu_props.sv */
// Protocol assertions for the fetch MMU top level.
`default_nettype none

module fetch_mmu_props
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_req,
        input  logic                  o_busy,
        input  logic                  o_done,
        input  logic                  o_ram_rd_en,
        input  fetch_mmu_pkg::word_t  o_ram_addr,
        input  logic                  i_ram_done
);
        timeunit 1ns;
        timeprecision 100ps;

        int unsigned fail_count = 0;                    // Read by the testbench at the end.

        // --------------------
        // Requester side.
        // --------------------
        a_req_idle: assert property (@(posedge i_clk) disable iff (i_reset)
                o_busy |-> !i_req)
        else
        begin
                fail_count++;
                $error("Request strobe while busy.");
        end

        a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
                o_done |=> !o_done)
        else
        begin
                fail_count++;
                $error("Done held longer than one cycle.");
        end

        // RAM read held with a steady address until answered.
        a_ram_hold: assert property (@(posedge i_clk) disable iff (i_reset)
                o_ram_rd_en && !i_ram_done |=> o_ram_rd_en && $stable(o_ram_addr))
        else
        begin
                fail_count++;
                $error("RAM read dropped or address moved before done.");
        end

        a_reset_quiet: assert property (@(posedge i_clk)
                i_reset |=> !o_busy && !o_ram_rd_en && !o_done)
        else
        begin
                fail_count++;
                $error("Outputs active after reset.");
        end

endmodule

bind fetch_mmu_top fetch_mmu_props u_props (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_ram_rd_en (o_ram_rd_en),
        .o_ram_addr  (o_ram_addr),
        .i_ram_done  (i_ram_done)
);

`default_nettype wire

/* verif/fetch_mmu_tb.sv */
// Fetch MMU testbench.
// RAM model with random latency, reference model, directed tests and response checker.
`default_nettype none

module fetch_mmu_tb;
        timeunit 1ns;
        timeprecision 100ps;
        import fetch_mmu_pkg::*;

        localparam int          MAX_CYCLES = 20000;     // 56 requests at a 30-cycle miss plus margin.
        localparam logic [31:0] SEED       = 32'd98;
        localparam word_t       TABLE_BASE = 32'h0003_c000;

        // DUT ports.
        logic        i_clk;
        logic        i_reset;
        logic        i_req;
        fetch_req_t  i_req_data;
        logic        o_busy;
        logic        o_done;
        fetch_rsp_t  o_rsp;
        logic        i_mmu_en;
        word_t       i_table_base;
        logic        i_inv;
        logic        o_ram_rd_en;
        word_t       o_ram_addr;
        logic        i_ram_done;
        word_t       i_ram_rd_data;

        word_t       ram [4096];                        // 16 KB with higher address bits aliased.
        logic [31:0] stim_state;
        logic [31:0] lat_state;                         // Separate stream for RAM latency.
        int unsigned ram_wait;
        logic        ram_busy;
        fetch_rsp_t  exp_rsp;                           // Expected answer of the request in flight.
        int unsigned last_lat;
        logic        last_saw_rd;
        int unsigned cycles = 0;
        int unsigned checks = 0;
        int unsigned errors = 0;
        int unsigned tests  = 0;

        fetch_mmu_top #(.TLB_ENTRIES(16), .CACHE_LINES(32)) i_dut (.*);

        // --------------------
        // Helpers.
        // --------------------
        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                return y ^ (y << 5);
        endfunction

        function automatic word_t section_desc(input logic [11:0] base, input logic [1:0] ap,
                                               input logic c, input logic [1:0] kind);
                section_desc_t d;
                d      = '0;
                d.base = base;
                d.ap   = ap;
                d.c    = c;
                d.kind = kind;
                return word_t'(d);
        endfunction

        // Word offset kept at index 0x800 and up, above the table words.
        function automatic word_t section_va(input logic [11:0] sec, input logic [31:0] r);
                return {sec, r[19:14], 1'b1, r[12:2], 2'b00};
        endfunction

        // Reference model of the flat map or the section walk with type and permission checks.
        function automatic fetch_rsp_t expect_fetch(input word_t va, input logic user,
                                                    input logic mmu_en, input word_t base);
                word_t         desc_addr;
                section_desc_t desc;
                word_t         pa;
                desc_addr = {base[31:14], va[31:20], 2'b00};
                desc      = section_desc_t'(ram[desc_addr[13:2]]);
                pa        = {desc.base, va[19:0]};
                if (!mmu_en)
                        return '{data: ram[va[13:2]], status: FAULT_NONE};
                if (desc.kind != 2'd2)
                        return '{data: '0, status: FAULT_TRANSLATION};
                if (user && !desc.ap[1])
                        return '{data: '0, status: FAULT_PERMISSION};
                return '{data: ram[pa[13:2]], status: FAULT_NONE};
        endfunction

        task automatic check_value(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
                end
        endtask

        // One request; returns after the edge that sees o_done.
        task automatic run_fetch(input word_t va, input logic user, input fetch_rsp_t exp);
                logic busy_held;
                @(negedge i_clk);
                i_req_data = '{vaddr: va, user: user};
                exp_rsp    = exp;
                i_req      = 1'b1;
                @(negedge i_clk);                       // Captured at the edge before.
                i_req       = 1'b0;
                last_lat    = 0;
                last_saw_rd = 1'b0;
                busy_held   = 1'b1;
                do
                begin
                        @(posedge i_clk);
                        last_lat++;
                        last_saw_rd = last_saw_rd | o_ram_rd_en;
                        busy_held   = busy_held & o_busy;   // Busy through the done cycle.
                end
                while (!o_done);
                check_value("o_busy", busy_held, 1);
        endtask

        task automatic fetch_checked(input word_t va, input logic user);
                run_fetch(va, user, expect_fetch(va, user, i_mmu_en, i_table_base));
        endtask

        task automatic report_test(input string name, input int unsigned errors_before);
                tests++;
                if (errors == errors_before)
                        $display("Test %0d %s: ok", tests, name);
                else
                        $display("Test %0d %s: %0d errors", tests, name, errors - errors_before);
        endtask

        // --------------------
        // Clock, timeout, RAM.
        // --------------------
        initial
        begin
                i_clk = 1'b0;
                forever #4 i_clk = ~i_clk;
        end

        always @(posedge i_clk)
        begin
                cycles++;
                if (cycles >= MAX_CYCLES)
                begin
                        $display("Timeout: run still going after %0d cycles.", cycles);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        // RAM answers 1 to 4 cycles after the read enable is seen.
        always @(negedge i_clk)
        begin
                i_ram_done = 1'b0;
                if (i_reset)
                        ram_busy = 1'b0;
                else if (o_ram_rd_en && !ram_busy)
                begin
                        lat_state = xorshift32(lat_state);
                        ram_wait  = 1 + lat_state[1:0];
                        ram_busy  = 1'b1;
                end
                if (ram_busy)
                begin
                        ram_wait--;
                        if (ram_wait == 0)
                        begin
                                i_ram_done    = 1'b1;
                                i_ram_rd_data = ram[o_ram_addr[13:2]];
                                ram_busy      = 1'b0;
                        end
                end
        end

        // Every answer against the expected one.
        always @(posedge i_clk)
        begin
                if (!i_reset && o_done)
                        check_value("o_rsp", o_rsp, exp_rsp);
        end

        // --------------------
        // Tests.
        // --------------------
        initial
        begin
                word_t       va;
                fetch_rsp_t  stale;
                int unsigned err0;
                int unsigned total;
                i_reset       = 1'b1;
                i_req         = 1'b0;
                i_req_data    = '0;
                i_mmu_en      = 1'b0;
                i_table_base  = TABLE_BASE;
                i_inv         = 1'b0;
                i_ram_done    = 1'b0;
                i_ram_rd_data = '0;
                ram_busy      = 1'b0;
                ram_wait      = 0;
                stim_state    = SEED;
                lat_state     = SEED;
                for (int i = 0; i < 4096; i++)
                        ram[i] = 32'h5a00_0000 ^ (i * 32'h9e37_79b1);
                // Sections 0x010 to 0x01f are cached with user access.
                for (int s = 0; s < 16; s++)
                begin
                        stim_state = xorshift32(stim_state);
                        ram[16 + s] = section_desc(stim_state[11:0], 2'b11, 1'b1, 2'd2);
                end
                ram[32] = section_desc(12'h3a5, 2'b11, 1'b1, 2'd1);    // Coarse type, no section.
                ram[33] = section_desc(12'h5c3, 2'b01, 1'b1, 2'd2);    // Supervisor only.
                ram[34] = section_desc(12'h777, 2'b11, 1'b1, 2'd2);    // Cached alias.
                ram[35] = section_desc(12'h777, 2'b11, 1'b0, 2'd2);    // Uncached alias.
                repeat (10) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;

                err0 = errors;
                for (int n = 0; n < 16; n++)
                begin
                        stim_state = xorshift32(stim_state);
                        fetch_checked(stim_state & ~32'h3, stim_state[31]);
                end
                report_test("mmu disabled", err0);

                @(negedge i_clk);
                i_mmu_en = 1'b1;
                err0     = errors;
                for (int n = 0; n < 16; n++)
                begin
                        stim_state = xorshift32(stim_state);
                        fetch_checked(section_va(12'h010 + 12'(n), stim_state), stim_state[31]);
                end
                report_test("translation", err0);

                err0 = errors;
                for (int n = 0; n < 8; n++)
                begin
                        stim_state = xorshift32(stim_state);
                        va = section_va(12'h010 + 12'(stim_state[3:0]), stim_state);
                        fetch_checked(va, 1'b0);
                        fetch_checked(va, 1'b0);        // Now a TLB and cache hit.
                        check_value("o_done latency", last_lat, 1);
                        check_value("o_ram_rd_en", last_saw_rd, 0);
                end
                report_test("hit timing", err0);

                err0 = errors;
                stim_state = xorshift32(stim_state);
                fetch_checked(section_va(12'h020, stim_state), 1'b1);
                fetch_checked(section_va(12'h020, stim_state), 1'b0);
                report_test("translation fault", err0);

                err0 = errors;
                fetch_checked(section_va(12'h021, stim_state), 1'b1);
                fetch_checked(section_va(12'h021, stim_state), 1'b0);
                report_test("permission fault", err0);

                err0 = errors;
                va = section_va(12'h022, stim_state);
                fetch_checked(va, 1'b0);                // Line now cached.
                stale = expect_fetch(va, 1'b0, i_mmu_en, i_table_base);
                @(negedge i_clk);
                ram[va[13:2]] = ~ram[va[13:2]];         // Changed behind the cache.
                fetch_checked({12'h023, va[19:0]}, 1'b0);
                run_fetch(va, 1'b0, stale);             // Cached alias still old.
                @(negedge i_clk);
                i_inv = 1'b1;
                @(negedge i_clk);
                i_inv = 1'b0;
                fetch_checked(va, 1'b0);
                report_test("uncached and invalidate", err0);

                total = errors + i_dut.u_props.fail_count;
                $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                         tests, checks, errors, i_dut.u_props.fail_count);
                if (total == 0)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

/* flist.f */
logic/fetch_mmu_pkg.sv
logic/section_tlb.sv
logic/line_cache.sv
logic/fetch_walker.sv
logic/fetch_mmu_top.sv
verif/fetch_mmu_props.sv
verif/fetch_mmu_tb.sv
